/* sblk_cfg_pkg.sv */
// Data types are signed two's complement; tile_idx_t covers at most 4 tiles and needs widening beyond
package sblk_cfg_pkg;

   // Datapath widths
   localparam int ACT_W  = 16;
   localparam int W_W    = 16;
   localparam int PSUM_W = 32;

   // Buffer index widths, each address wraps at its own width
   localparam int ACT_AW  = 6;
   localparam int W_AW    = 10;
   localparam int PSUM_AW = 9;

   // Tile select width, enough for the default of four tiles
   localparam int TILE_IDX_W = 2;

   // One activation sample
   typedef logic signed [ACT_W-1:0] act_t;

   // One weight
   typedef logic signed [W_W-1:0] w_t;

   // Product, cascade sum and psum entry all share this width
   // Sums wrap at 32 bits
   typedef logic signed [PSUM_W-1:0] psum_t;

   // Activation index, also the step index of an instruction
   typedef logic [ACT_AW-1:0] act_addr_t;

   // Weight buffer index
   typedef logic [W_AW-1:0] w_addr_t;

   // Partial-sum buffer index
   typedef logic [PSUM_AW-1:0] psum_addr_t;

   // Host tile select for buffer writes
   typedef logic [TILE_IDX_W-1:0] tile_idx_t;

endpackage

/* sblk_inst_pkg.sv */
// Instruction is count, weight base, psum base, accumulate flag from MSB down; no loop fields
package sblk_inst_pkg;

   // Field widths
   localparam int INST_COUNT_W = 6;
   localparam int INST_WBASE_W = 10;
   localparam int INST_PBASE_W = 9;
   localparam int INST_W       = INST_COUNT_W + INST_WBASE_W + INST_PBASE_W + 1;

   // Field positions, accumulate flag sits in bit 0
   localparam int INST_ACC_POS   = 0;
   localparam int INST_PBASE_LSB = INST_ACC_POS + 1;
   localparam int INST_WBASE_LSB = INST_PBASE_LSB + INST_PBASE_W;
   localparam int INST_COUNT_LSB = INST_WBASE_LSB + INST_WBASE_W;

   // Whole instruction word
   typedef logic [INST_W-1:0] inst_t;

   // Individual fields
   typedef logic [INST_COUNT_W-1:0] inst_count_t;
   typedef logic [INST_WBASE_W-1:0] inst_wbase_t;
   typedef logic [INST_PBASE_W-1:0] inst_pbase_t;

   // Controller states
   // IDLE waits for an instruction, ISSUE sends one step per cycle,
   // DRAIN lets the cascade and psum writes finish
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      DRAIN
   } ctrl_state_t;

endpackage

/* tile_mac.sv */
// Buffers have no reset and hold garbage until written; host writes while busy are not supported
`timescale 1ns/1ps

module tile_mac (
   input  logic                    clk_h,
   input  logic                    rst_n,
   input  logic                    act_wr_en,
   input  sblk_cfg_pkg::act_addr_t act_wr_addr,
   input  sblk_cfg_pkg::act_t      act_wr_data,
   input  logic                    w_wr_en,
   input  sblk_cfg_pkg::w_addr_t   w_wr_addr,
   input  sblk_cfg_pkg::w_t        w_wr_data,
   input  sblk_cfg_pkg::act_addr_t act_rd_addr,
   input  sblk_cfg_pkg::w_addr_t   w_rd_addr,
   input  sblk_cfg_pkg::psum_t     cas_in,
   output sblk_cfg_pkg::psum_t     cas_out
);

   localparam int ACT_DEPTH = 2 ** $bits(sblk_cfg_pkg::act_addr_t);
   localparam int W_DEPTH   = 2 ** $bits(sblk_cfg_pkg::w_addr_t);

   // Private buffers of this tile
   sblk_cfg_pkg::act_t  act_mem [ACT_DEPTH];
   sblk_cfg_pkg::w_t    w_mem [W_DEPTH];

   // Registered read data
   sblk_cfg_pkg::act_t  act_q;
   sblk_cfg_pkg::w_t    w_q;

   sblk_cfg_pkg::psum_t prod;

   // Host write ports
   always_ff @(posedge clk_h) begin
      if (act_wr_en) begin
         act_mem[act_wr_addr] <= act_wr_data;
      end
   end

   always_ff @(posedge clk_h) begin
      if (w_wr_en) begin
         w_mem[w_wr_addr] <= w_wr_data;
      end
   end

   // One cycle read, both buffers in lock step
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         act_q <= '0;
         w_q   <= '0;
      end else begin
         act_q <= act_mem[act_rd_addr];
         w_q   <= w_mem[w_rd_addr];
      end
   end

   // Signed product, 16x16 always fits in 32 bits
   assign prod = sblk_cfg_pkg::psum_t'(act_q) * sblk_cfg_pkg::psum_t'(w_q);

   // Cascade stage; the upstream sum arrives in the same cycle as the product
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         cas_out <= '0;
      end else begin
         cas_out <= cas_in + prod;
      end
   end

endmodule

/* tile_chain.sv */
// Needs N_TILE from 2 to 4; tile selects above N_TILE - 1 write nowhere
`timescale 1ns/1ps

module tile_chain #(
   parameter int N_TILE = 4
) (
   input  logic                    clk_h,
   input  logic                    rst_n,
   input  logic                    act_wr_en,
   input  sblk_cfg_pkg::tile_idx_t act_wr_tile,
   input  sblk_cfg_pkg::act_addr_t act_wr_addr,
   input  sblk_cfg_pkg::act_t      act_wr_data,
   input  logic                    w_wr_en,
   input  sblk_cfg_pkg::tile_idx_t w_wr_tile,
   input  sblk_cfg_pkg::w_addr_t   w_wr_addr,
   input  sblk_cfg_pkg::w_t        w_wr_data,
   input  logic                    step_vld,
   input  sblk_cfg_pkg::act_addr_t act_rd_addr,
   input  sblk_cfg_pkg::w_addr_t   w_rd_addr,
   output logic                    chain_vld,
   output sblk_cfg_pkg::psum_t     chain_sum
);

   logic [N_TILE-1:0]       act_we;
   logic [N_TILE-1:0]       w_we;

   // Skew registers, entry j is delayed j + 1 cycles
   sblk_cfg_pkg::act_addr_t act_sk_q [N_TILE-1];
   sblk_cfg_pkg::w_addr_t   w_sk_q [N_TILE-1];
   // Per-tile read address taps
   sblk_cfg_pkg::act_addr_t act_tap [N_TILE];
   sblk_cfg_pkg::w_addr_t   w_tap [N_TILE];

   // Cascade links, entry 0 feeds the first tile
   sblk_cfg_pkg::psum_t     cas [N_TILE+1];
   logic [N_TILE:0]         vld_sr;

   // Tile select decode
   always_comb begin
      for (int i = 0; i < N_TILE; i++) begin
         act_we[i] = act_wr_en && (act_wr_tile == sblk_cfg_pkg::tile_idx_t'(i));
         w_we[i]   = w_wr_en && (w_wr_tile == sblk_cfg_pkg::tile_idx_t'(i));
      end
   end

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int j = 0; j < N_TILE - 1; j++) begin
            act_sk_q[j] <= '0;
            w_sk_q[j]   <= '0;
         end
         vld_sr <= '0;
      end else begin
         act_sk_q[0] <= act_rd_addr;
         w_sk_q[0]   <= w_rd_addr;
         for (int j = 1; j < N_TILE - 1; j++) begin
            act_sk_q[j] <= act_sk_q[j-1];
            w_sk_q[j]   <= w_sk_q[j-1];
         end
         // Valid rides N_TILE + 1 stages to meet the last cascade output
         vld_sr <= {vld_sr[N_TILE-1:0], step_vld};
      end
   end

   // Tile 0 reads straight away, tile i sees the addresses i cycles late
   always_comb begin
      act_tap[0] = act_rd_addr;
      w_tap[0]   = w_rd_addr;
      for (int i = 1; i < N_TILE; i++) begin
         act_tap[i] = act_sk_q[i-1];
         w_tap[i]   = w_sk_q[i-1];
      end
   end

   assign cas[0] = '0;

   for (genvar i = 0; i < N_TILE; i++) begin : g_tile
      tile_mac u_tile (
         .clk_h      (clk_h),
         .rst_n      (rst_n),
         .act_wr_en  (act_we[i]),
         .act_wr_addr(act_wr_addr),
         .act_wr_data(act_wr_data),
         .w_wr_en    (w_we[i]),
         .w_wr_addr  (w_wr_addr),
         .w_wr_data  (w_wr_data),
         .act_rd_addr(act_tap[i]),
         .w_rd_addr  (w_tap[i]),
         .cas_in     (cas[i]),
         .cas_out    (cas[i+1])
      );
   end

   assign chain_sum = cas[N_TILE];
   assign chain_vld = vld_sr[N_TILE];

endmodule

/* psum_buffer.sv */
// Assumes one instruction never revisits an address; unwritten entries read back as zero
`timescale 1ns/1ps

module psum_buffer (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  logic                     chain_vld,
   input  sblk_cfg_pkg::psum_t      chain_sum,
   input  sblk_cfg_pkg::psum_addr_t acc_addr,
   input  logic                     acc_mode,
   input  logic                     psum_rd_en,
   input  sblk_cfg_pkg::psum_addr_t psum_rd_addr,
   output sblk_cfg_pkg::psum_t      psum_rd_data,
   output logic                     psum_rd_vld
);

   localparam int DEPTH = 2 ** $bits(sblk_cfg_pkg::psum_addr_t);

   sblk_cfg_pkg::psum_t      mem [DEPTH];
   // Per-entry written flag, cleared by reset so the buffer starts at zero
   logic [DEPTH-1:0]         written;

   sblk_cfg_pkg::psum_t      old_val;
   sblk_cfg_pkg::psum_t      new_val;

   // Write stage
   logic                     wr_vld;
   sblk_cfg_pkg::psum_addr_t wr_addr;
   sblk_cfg_pkg::psum_t      wr_data;

   // First host read stage
   logic                     rd_vld_q;
   sblk_cfg_pkg::psum_t      rd_data_q;

   // Old value read in the chain_vld cycle
   assign old_val = written[acc_addr] ? mem[acc_addr] : '0;
   assign new_val = acc_mode ? old_val + chain_sum : chain_sum;

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         wr_vld  <= 1'b0;
         wr_addr <= '0;
         wr_data <= '0;
      end else begin
         wr_vld  <= chain_vld;
         wr_addr <= acc_addr;
         wr_data <= new_val;
      end
   end

   // Write lands one cycle after chain_vld
   always_ff @(posedge clk_h) begin
      if (wr_vld) begin
         mem[wr_addr] <= wr_data;
      end
   end

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         written <= '0;
      end else if (wr_vld) begin
         written[wr_addr] <= 1'b1;
      end
   end

   // Host read, two register stages
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q     <= 1'b0;
         rd_data_q    <= '0;
         psum_rd_vld  <= 1'b0;
         psum_rd_data <= '0;
      end else begin
         rd_vld_q     <= psum_rd_en;
         rd_data_q    <= written[psum_rd_addr] ? mem[psum_rd_addr] : '0;
         psum_rd_vld  <= rd_vld_q;
         psum_rd_data <= rd_data_q;
      end
   end

endmodule

/* sblk_ctrl.sv */
// Instructions during busy are dropped; drain length assumes the chain latency of N_TILE + 1
`timescale 1ns/1ps

module sblk_ctrl #(
   parameter int N_TILE = 4
) (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  logic                     inst_en,
   input  sblk_inst_pkg::inst_t     inst_data,
   output logic                     step_vld,
   output sblk_cfg_pkg::act_addr_t  act_rd_addr,
   output sblk_cfg_pkg::w_addr_t    w_rd_addr,
   output sblk_cfg_pkg::psum_addr_t acc_addr,
   output logic                     acc_mode,
   output logic                     busy,
   output logic                     done
);

   // Step to chain_vld latency, one skew cycle per tile plus the buffer read
   localparam int LAT       = N_TILE + 1;
   // Cycles from the last step until the last psum write has landed
   localparam int DRAIN_CYC = N_TILE + 2;
   localparam int DRAIN_W   = $clog2(DRAIN_CYC + 1);

   sblk_inst_pkg::ctrl_state_t state;

   // Fields of the incoming instruction
   sblk_inst_pkg::inst_count_t in_cnt;
   sblk_inst_pkg::inst_wbase_t in_wbase;
   sblk_inst_pkg::inst_pbase_t in_pbase;
   logic                       in_acc;

   // Latched instruction
   sblk_inst_pkg::inst_count_t cnt_q;
   sblk_inst_pkg::inst_wbase_t wbase_q;
   sblk_inst_pkg::inst_pbase_t pbase_q;
   logic                       acc_q;

   sblk_inst_pkg::inst_count_t step_q;
   logic [DRAIN_W-1:0]         drain_q;
   logic                       last_step;
   sblk_cfg_pkg::psum_addr_t   issue_paddr;

   // Psum address and mode delay line, matched to the chain
   sblk_cfg_pkg::psum_addr_t   addr_dl [LAT];
   logic [LAT-1:0]             mode_dl;

   assign in_cnt   = inst_data[sblk_inst_pkg::INST_COUNT_LSB +: sblk_inst_pkg::INST_COUNT_W];
   assign in_wbase = inst_data[sblk_inst_pkg::INST_WBASE_LSB +: sblk_inst_pkg::INST_WBASE_W];
   assign in_pbase = inst_data[sblk_inst_pkg::INST_PBASE_LSB +: sblk_inst_pkg::INST_PBASE_W];
   assign in_acc   = inst_data[sblk_inst_pkg::INST_ACC_POS];

   // Count is nonzero whenever ISSUE is entered
   assign last_step = (step_q == cnt_q - 1'b1);

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         state   <= sblk_inst_pkg::IDLE;
         cnt_q   <= '0;
         wbase_q <= '0;
         pbase_q <= '0;
         acc_q   <= 1'b0;
         step_q  <= '0;
         drain_q <= '0;
      end else begin
         case (state)
            sblk_inst_pkg::IDLE: begin
               if (inst_en) begin
                  cnt_q   <= in_cnt;
                  wbase_q <= in_wbase;
                  pbase_q <= in_pbase;
                  acc_q   <= in_acc;
                  step_q  <= '0;
                  // Zero count skips straight to the done countdown
                  if (in_cnt == '0) begin
                     state   <= sblk_inst_pkg::DRAIN;
                     drain_q <= DRAIN_W'(DRAIN_CYC);
                  end else begin
                     state <= sblk_inst_pkg::ISSUE;
                  end
               end
            end
            sblk_inst_pkg::ISSUE: begin
               step_q <= step_q + 1'b1;
               if (last_step) begin
                  state   <= sblk_inst_pkg::DRAIN;
                  drain_q <= DRAIN_W'(DRAIN_CYC);
               end
            end
            sblk_inst_pkg::DRAIN: begin
               if (drain_q == '0) begin
                  state <= sblk_inst_pkg::IDLE;
               end else begin
                  drain_q <= drain_q - 1'b1;
               end
            end
            default: state <= sblk_inst_pkg::IDLE;
         endcase
      end
   end

   // One step per ISSUE cycle, addresses rise with the step
   assign step_vld    = (state == sblk_inst_pkg::ISSUE);
   assign act_rd_addr = sblk_cfg_pkg::act_addr_t'(step_q);
   assign w_rd_addr   = sblk_cfg_pkg::w_addr_t'(wbase_q + sblk_inst_pkg::inst_wbase_t'(step_q));
   assign issue_paddr = sblk_cfg_pkg::psum_addr_t'(pbase_q + sblk_inst_pkg::inst_pbase_t'(step_q));

   // done is the last busy cycle
   assign busy = (state != sblk_inst_pkg::IDLE);
   assign done = (state == sblk_inst_pkg::DRAIN) && (drain_q == '0);

   // Destination and mode travel alongside the cascade
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         for (int j = 0; j < LAT; j++) begin
            addr_dl[j] <= '0;
         end
         mode_dl <= '0;
      end else begin
         addr_dl[0] <= issue_paddr;
         mode_dl[0] <= acc_q;
         for (int j = 1; j < LAT; j++) begin
            addr_dl[j] <= addr_dl[j-1];
            mode_dl[j] <= mode_dl[j-1];
         end
      end
   end

   assign acc_addr = addr_dl[LAT-1];
   assign acc_mode = mode_dl[LAT-1];

endmodule

/* sblk.sv */
// Single clock, no back-pressure; buffer writes and instructions are ignored or unsupported while busy
`timescale 1ns/1ps

module sblk #(
   parameter int N_TILE = 4
) (
   input  logic                     clk_h,
   input  logic                     rst_n,
   input  logic                     act_wr_en,
   input  sblk_cfg_pkg::tile_idx_t  act_wr_tile,
   input  sblk_cfg_pkg::act_addr_t  act_wr_addr,
   input  sblk_cfg_pkg::act_t       act_wr_data,
   input  logic                     w_wr_en,
   input  sblk_cfg_pkg::tile_idx_t  w_wr_tile,
   input  sblk_cfg_pkg::w_addr_t    w_wr_addr,
   input  sblk_cfg_pkg::w_t         w_wr_data,
   input  logic                     inst_en,
   input  sblk_inst_pkg::inst_t     inst_data,
   input  logic                     psum_rd_en,
   input  sblk_cfg_pkg::psum_addr_t psum_rd_addr,
   output sblk_cfg_pkg::psum_t      psum_rd_data,
   output logic                     psum_rd_vld,
   output logic                     busy,
   output logic                     done
);

   // Controller to chain
   logic                     step_vld;
   sblk_cfg_pkg::act_addr_t  act_rd_addr;
   sblk_cfg_pkg::w_addr_t    w_rd_addr;

   // Chain and controller to psum buffer
   logic                     chain_vld;
   sblk_cfg_pkg::psum_t      chain_sum;
   sblk_cfg_pkg::psum_addr_t acc_addr;
   logic                     acc_mode;

   sblk_ctrl #(
      .N_TILE(N_TILE)
   ) u_ctrl (
      .clk_h      (clk_h),
      .rst_n      (rst_n),
      .inst_en    (inst_en),
      .inst_data  (inst_data),
      .step_vld   (step_vld),
      .act_rd_addr(act_rd_addr),
      .w_rd_addr  (w_rd_addr),
      .acc_addr   (acc_addr),
      .acc_mode   (acc_mode),
      .busy       (busy),
      .done       (done)
   );

   tile_chain #(
      .N_TILE(N_TILE)
   ) u_chain (
      .clk_h      (clk_h),
      .rst_n      (rst_n),
      .act_wr_en  (act_wr_en),
      .act_wr_tile(act_wr_tile),
      .act_wr_addr(act_wr_addr),
      .act_wr_data(act_wr_data),
      .w_wr_en    (w_wr_en),
      .w_wr_tile  (w_wr_tile),
      .w_wr_addr  (w_wr_addr),
      .w_wr_data  (w_wr_data),
      .step_vld   (step_vld),
      .act_rd_addr(act_rd_addr),
      .w_rd_addr  (w_rd_addr),
      .chain_vld  (chain_vld),
      .chain_sum  (chain_sum)
   );

   psum_buffer u_psum (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .chain_vld   (chain_vld),
      .chain_sum   (chain_sum),
      .acc_addr    (acc_addr),
      .acc_mode    (acc_mode),
      .psum_rd_en  (psum_rd_en),
      .psum_rd_addr(psum_rd_addr),
      .psum_rd_data(psum_rd_data),
      .psum_rd_vld (psum_rd_vld)
   );

endmodule

/* sblk_asserts.sv */
// Top-level protocol checks bound into sblk; only ports of the top level are observed
`timescale 1ns/1ps

module sblk_asserts (
   input logic clk_h,
   input logic rst_n,
   input logic busy,
   input logic done,
   input logic psum_rd_en,
   input logic psum_rd_vld
);

   // done is only seen inside a busy window
   done_in_busy: assert property (@(posedge clk_h) disable iff (!rst_n) done |-> busy)
      else $error("done pulsed while not busy");

   // Host read valid trails the request by two cycles exactly
   rd_latency: assert property (@(posedge clk_h) disable iff (!rst_n)
      psum_rd_vld == $past(psum_rd_en, 2))
      else $error("psum_rd_vld does not follow psum_rd_en by two cycles");

   // done is the last busy cycle
   busy_ends: assert property (@(posedge clk_h) disable iff (!rst_n) done |=> !busy)
      else $error("busy still high after done");

   busy_fall: assert property (@(posedge clk_h) disable iff (!rst_n) $fell(busy) |-> $past(done))
      else $error("busy fell without done");

   // Outputs quiet in reset
   reset_quiet: assert property (@(posedge clk_h) !rst_n |-> (!busy && !done && !psum_rd_vld))
      else $error("outputs active during reset");

endmodule

bind sblk sblk_asserts u_asserts (
   .clk_h      (clk_h),
   .rst_n      (rst_n),
   .busy       (busy),
   .done       (done),
   .psum_rd_en (psum_rd_en),
   .psum_rd_vld(psum_rd_vld)
);

/* sblk_tb.sv */
// Runs records from sblk_tests.txt in the project root; model assumes every used buffer entry is written first
`timescale 1ns/1ps

module sblk_tb;

   localparam int N_TILE     = 4;
   localparam int ACT_DEPTH  = 64;
   localparam int W_DEPTH    = 1024;
   localparam int PSUM_DEPTH = 512;

   logic                     clk_h;
   logic                     rst_n;
   logic                     act_wr_en;
   sblk_cfg_pkg::tile_idx_t  act_wr_tile;
   sblk_cfg_pkg::act_addr_t  act_wr_addr;
   sblk_cfg_pkg::act_t       act_wr_data;
   logic                     w_wr_en;
   sblk_cfg_pkg::tile_idx_t  w_wr_tile;
   sblk_cfg_pkg::w_addr_t    w_wr_addr;
   sblk_cfg_pkg::w_t         w_wr_data;
   logic                     inst_en;
   sblk_inst_pkg::inst_t     inst_data;
   logic                     psum_rd_en;
   sblk_cfg_pkg::psum_addr_t psum_rd_addr;
   sblk_cfg_pkg::psum_t      psum_rd_data;
   logic                     psum_rd_vld;
   logic                     busy;
   logic                     done;

   // Mirror of the tile buffers and the psum buffer
   sblk_cfg_pkg::act_t       act_m [N_TILE][ACT_DEPTH];
   sblk_cfg_pkg::w_t         w_m [N_TILE][W_DEPTH];
   sblk_cfg_pkg::psum_t      psum_m [PSUM_DEPTH];

   string                    recs [$];
   int                       err_cnt = 0;
   int                       done_cnt = 0;
   int                       cycle_cnt = 0;
   int                       cycle_limit = 1000;
   int                       seed = 10830;

   sblk #(
      .N_TILE(N_TILE)
   ) DUT (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .act_wr_en   (act_wr_en),
      .act_wr_tile (act_wr_tile),
      .act_wr_addr (act_wr_addr),
      .act_wr_data (act_wr_data),
      .w_wr_en     (w_wr_en),
      .w_wr_tile   (w_wr_tile),
      .w_wr_addr   (w_wr_addr),
      .w_wr_data   (w_wr_data),
      .inst_en     (inst_en),
      .inst_data   (inst_data),
      .psum_rd_en  (psum_rd_en),
      .psum_rd_addr(psum_rd_addr),
      .psum_rd_data(psum_rd_data),
      .psum_rd_vld (psum_rd_vld),
      .busy        (busy),
      .done        (done)
   );

   // 20 ns clock
   initial clk_h = 1'b0;
   always #10 clk_h = ~clk_h;

   // Count done pulses where the outputs are stable
   always @(negedge clk_h) begin
      if (done) begin
         done_cnt++;
      end
   end

   // Watchdog, limit is set from the record count at time 0
   initial begin
      #1;
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk_h);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic check_psum(input string what, input sblk_cfg_pkg::psum_t got,
                             input sblk_cfg_pkg::psum_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %h, expected %h", $realtime, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %b, expected %b", $realtime, what, got, exp);
         err_cnt++;
      end
   endtask

   // Field order from the MSB: count, weight base, psum base, accumulate
   function automatic sblk_inst_pkg::inst_t make_inst(input int cnt, input int wbase,
                                                      input int pbase, input logic acc);
      return {sblk_inst_pkg::inst_count_t'(cnt), sblk_inst_pkg::inst_wbase_t'(wbase),
              sblk_inst_pkg::inst_pbase_t'(pbase), acc};
   endfunction

   // All drive tasks start and end 2 ns after a rising edge
   task automatic write_act(input int tile, input int addr, input int data);
      act_wr_en   = 1'b1;
      act_wr_tile = sblk_cfg_pkg::tile_idx_t'(tile);
      act_wr_addr = sblk_cfg_pkg::act_addr_t'(addr);
      act_wr_data = sblk_cfg_pkg::act_t'(data);
      @(posedge clk_h);
      #2;
      act_wr_en = 1'b0;
      act_m[tile][addr % ACT_DEPTH] = sblk_cfg_pkg::act_t'(data);
   endtask

   task automatic write_weight(input int tile, input int addr, input int data);
      w_wr_en   = 1'b1;
      w_wr_tile = sblk_cfg_pkg::tile_idx_t'(tile);
      w_wr_addr = sblk_cfg_pkg::w_addr_t'(addr);
      w_wr_data = sblk_cfg_pkg::w_t'(data);
      @(posedge clk_h);
      #2;
      w_wr_en = 1'b0;
      w_m[tile][addr % W_DEPTH] = sblk_cfg_pkg::w_t'(data);
   endtask

   // Issue one instruction, optionally a second one while busy, wait for done
   task automatic run_inst(input int cnt, input int wbase, input int pbase, input logic acc,
                           input int extra);
      int                  base;
      int                  waited;
      int                  pa;
      sblk_cfg_pkg::psum_t s;
      base      = done_cnt;
      waited    = 0;
      inst_en   = 1'b1;
      inst_data = make_inst(cnt, wbase, pbase, acc);
      @(posedge clk_h);
      #2;
      inst_en = 1'b0;
      check_flag("busy after accept", busy, 1'b1);
      if (extra != 0) begin
         // Would land one entry higher if it were taken
         inst_en   = 1'b1;
         inst_data = make_inst(cnt, wbase, pbase + 1, ~acc);
         @(posedge clk_h);
         #2;
         inst_en = 1'b0;
      end
      while (done_cnt == base && waited < cnt + 4 * N_TILE + 16) begin
         @(posedge clk_h);
         #2;
         waited++;
      end
      if (done_cnt == base) begin
         $display("No done pulse after %0d cycles for count %0d", waited, cnt);
         err_cnt++;
      end
      repeat (N_TILE + 4) @(posedge clk_h);
      #2;
      check_flag("busy after done", busy, 1'b0);
      check_flag("single done pulse", done_cnt == base + 1, 1'b1);
      // Sum over tiles of activation times weight, wrap at 32 bits
      for (int k = 0; k < cnt; k++) begin
         s = '0;
         for (int i = 0; i < N_TILE; i++) begin
            s += sblk_cfg_pkg::psum_t'(act_m[i][k]) *
                 sblk_cfg_pkg::psum_t'(w_m[i][(wbase + k) % W_DEPTH]);
         end
         pa = (pbase + k) % PSUM_DEPTH;
         psum_m[pa] = acc ? psum_m[pa] + s : s;
      end
   endtask

   task automatic read_psum(input int addr, output sblk_cfg_pkg::psum_t data);
      int waited;
      waited       = 0;
      data         = '0;
      psum_rd_en   = 1'b1;
      psum_rd_addr = sblk_cfg_pkg::psum_addr_t'(addr);
      @(posedge clk_h);
      #2;
      psum_rd_en = 1'b0;
      @(negedge clk_h);
      while (!psum_rd_vld && waited < 4) begin
         @(negedge clk_h);
         waited++;
      end
      if (psum_rd_vld) begin
         data = psum_rd_data;
      end else begin
         $display("Read of psum address %0d never returned valid data", addr);
         err_cnt++;
      end
      @(posedge clk_h);
      #2;
   endtask

   // Random buffers over the used range, random instruction, full readback
   task automatic run_random();
      int                  cnt;
      int                  wbase;
      int                  pbase;
      logic                acc;
      sblk_cfg_pkg::psum_t data;
      cnt   = 1 + int'($unsigned($random(seed)) % 63);
      wbase = int'($unsigned($random(seed)) % W_DEPTH);
      pbase = int'($unsigned($random(seed)) % PSUM_DEPTH);
      acc   = ($random(seed) & 1) != 0;
      $display("Random run: count %0d, wbase %0d, pbase %0d, acc %0b", cnt, wbase, pbase, acc);
      for (int k = 0; k < cnt; k++) begin
         for (int i = 0; i < N_TILE; i++) begin
            write_act(i, k, $random(seed));
            write_weight(i, (wbase + k) % W_DEPTH, $random(seed));
         end
      end
      run_inst(cnt, wbase, pbase, acc, 0);
      for (int k = 0; k < cnt; k++) begin
         read_psum((pbase + k) % PSUM_DEPTH, data);
         check_psum($sformatf("psum[%0d]", (pbase + k) % PSUM_DEPTH), data,
                    psum_m[(pbase + k) % PSUM_DEPTH]);
      end
   endtask

   initial begin
      int                  fd;
      int                  err_before;
      int                  n_pass;
      int                  n_fail;
      string               line;
      logic [7:0]          tag;
      logic [31:0]         f0;
      logic [31:0]         f1;
      logic [31:0]         f2;
      logic [31:0]         f3;
      logic [31:0]         f4;
      sblk_cfg_pkg::psum_t data;
      $timeformat(-9, 0, " ns", 0);
      n_pass       = 0;
      n_fail       = 0;
      rst_n        = 1'b0;
      act_wr_en    = 1'b0;
      act_wr_tile  = '0;
      act_wr_addr  = '0;
      act_wr_data  = '0;
      w_wr_en      = 1'b0;
      w_wr_tile    = '0;
      w_wr_addr    = '0;
      w_wr_data    = '0;
      inst_en      = 1'b0;
      inst_data    = '0;
      psum_rd_en   = 1'b0;
      psum_rd_addr = '0;
      for (int a = 0; a < PSUM_DEPTH; a++) begin
         psum_m[a] = '0;
      end
      // Skip comments and blank lines, strip the newline
      fd = $fopen("sblk_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open sblk_tests.txt");
         err_cnt++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[line.len()-1] == "\n") begin
               line = line.substr(0, line.len() - 2);
            end
            if (line.len() > 0 && line[0] != "#") begin
               recs.push_back(line);
            end
         end
         $fclose(fd);
      end
      cycle_limit = 200 * recs.size() + 1000;
      repeat (10) @(posedge clk_h);
      #2;
      rst_n = 1'b1;
      check_flag("busy after reset", busy, 1'b0);
      check_flag("done after reset", done, 1'b0);
      $display("Test reset: %s", (err_cnt == 0) ? "passed" : "failed");
      for (int n = 0; n < recs.size(); n++) begin
         err_before = err_cnt;
         tag        = recs[n][0];
         f0         = '0;
         f1         = '0;
         f2         = '0;
         f3         = '0;
         f4         = '0;
         void'($sscanf(recs[n].substr(1, recs[n].len() - 1), "%h %h %h %h %h",
                       f0, f1, f2, f3, f4));
         case (tag)
            "W": write_weight(f0, f1, f2);
            "A": write_act(f0, f1, f2);
            "I": run_inst(f0, f1, f2, f3[0], f4);
            "R": begin
               read_psum(f0, data);
               check_psum($sformatf("psum[%0d] vs record", f0), data, f1);
               check_psum($sformatf("psum[%0d] vs model", f0), data, psum_m[f0 % PSUM_DEPTH]);
            end
            "X": run_random();
            default: begin
               $display("Unknown record tag in line: %s", recs[n]);
               err_cnt++;
            end
         endcase
         if (err_cnt == err_before) begin
            n_pass++;
         end else begin
            n_fail++;
         end
         $display("Test %0d [%s]: %s", n + 1, recs[n], (err_cnt == err_before) ? "passed" : "failed");
      end
      $display("Done: %0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* sblk_tests.txt */
# Tag then hex fields. W and A: tile, address, data. I: count, wbase, pbase, acc, extra inst
# R: psum address, expected value. X: randomized run, no fields
# Reset state, psum reads back as zero
R 000 00000000
R 1ff 00000000
# Activations for steps 0 and 1, step 1 near the extremes
A 0 00 0003
A 1 00 0005
A 2 00 0007
A 3 00 000b
A 0 01 7fff
A 1 01 7fff
A 2 01 8000
A 3 01 7fff
# One-hot weights at address 0, extreme weights at address 1
W 0 000 0000
W 1 000 0000
W 2 000 0001
W 3 000 0000
W 0 001 7fff
W 1 001 7fff
W 2 001 8000
W 3 001 7fff
# Two steps without accumulate, step 1 wraps at 32 bits
I 02 000 000 0 0
R 000 00000007
R 001 fffd0003
# Same instruction with accumulate doubles both entries
I 02 000 000 1 0
R 000 0000000e
R 001 fffa0006
# Shifted weight and psum bases, other entries keep their values
I 01 001 010 0 0
R 010 0005ffed
R 011 00000000
R 00f 00000000
R 001 fffa0006
# Zero count, then a second instruction sent while busy
I 00 000 000 0 0
R 000 0000000e
I 01 000 020 0 1
R 020 00000007
R 021 00000000
# Random buffers and instruction
X

/* sources.f */
sblk_cfg_pkg.sv
sblk_inst_pkg.sv
tile_mac.sv
tile_chain.sv
psum_buffer.sv
sblk_ctrl.sv
sblk.sv
sblk_asserts.sv
sblk_tb.sv

/* Makefile */
# Verilator build and run of the sblk testbench

TOP = sblk_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
